/* sdf_fft_top.f */
rtl/fft_pkg.sv
rtl/twiddle_pkg.sv
rtl/sdf_delay_line.sv
rtl/sdf_bf_stage.sv
rtl/sdf_twiddle_mul.sv
rtl/sdf_fft_top.sv
bench/tb_sdf_fft_top.sv

/* run.sh */
#!/bin/sh
# Build the FFT testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sdf_fft_top \
	-f sdf_fft_top.f || exit 1
out=$(./obj_dir/Vtb_sdf_fft_top 2>&1)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1

/* bench/tb_sdf_fft_top.sv */
module tb_sdf_fft_top import fft_pkg::*;
;
	localparam int NUM_FRAMES     = 4;	// Rows in the frame table
	localparam int AMP            = 100;	// Stimulus amplitude
	localparam int TIMEOUT_CYCLES = (NUM_FRAMES + 2) * FFT_N * 2 + 64;	// Gaps can double the run

	localparam int RULE_IMPULSE = 0;	// A at sample 0
	localparam int RULE_DC      = 1;	// A everywhere
	localparam int RULE_ALT     = 2;	// +A, -A, ...
	localparam int RULE_COS     = 3;	// A, 0, -A, 0, ...
	localparam int RULE_ZERO    = 4;	// Flush frame

	logic    CLK;
	logic    RST;
	logic    valid_i;
	cplx12_t data_i;
	logic    valid_o;
	logic    first_o;
	cplx16_t data_o;

	logic [31:0] lfsr = 32'h86d9_7107;	// Gap generator state
	int          cycle_cnt   = 0;
	int          sample_idx  = 0;	// Output position inside the current frame
	int          frames_done = 0;
	bit          started     = 1'b0;	// First frame has reached the output

	// Frame table with bins in natural order
	string frame_name [NUM_FRAMES] = '{"impulse", "dc", "alternating", "quarter_cosine"};
	int    frame_rule [NUM_FRAMES] = '{RULE_IMPULSE, RULE_DC, RULE_ALT, RULE_COS};
	int    bin_re [NUM_FRAMES][FFT_N] = '{
		'{AMP, AMP, AMP, AMP, AMP, AMP, AMP, AMP, AMP, AMP, AMP, AMP, AMP, AMP, AMP, AMP},
		'{16 * AMP, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},	// All energy at DC
		'{0, 0, 0, 0, 0, 0, 0, 0, 16 * AMP, 0, 0, 0, 0, 0, 0, 0},	// Nyquist bin
		'{0, 0, 0, 0, 8 * AMP, 0, 0, 0, 0, 0, 0, 0, 8 * AMP, 0, 0, 0}	// Bins 4 and 12
	};
	int    bin_im [NUM_FRAMES][FFT_N] = '{default: 0};	// Real even inputs

	sdf_fft_top u_sdf_fft_top (
		.CLK     (CLK),
		.RST     (RST),
		.valid_i (valid_i),
		.data_i  (data_i),
		.valid_o (valid_o),
		.first_o (first_o),
		.data_o  (data_o)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;	// Period 4

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int bit_reverse(input int k);
		int r;
		r = 0;
		for (int i = 0; i < LOG2_N; i++)
			r = (r << 1) | ((k >> i) & 1);	// LSB of k becomes MSB
		return r;
	endfunction

	function automatic cplx12_t make_sample(input int rule, input int n);
		cplx12_t s;
		int      re;
		case (rule)
			RULE_IMPULSE: re = (n == 0) ? AMP : 0;
			RULE_DC:      re = AMP;
			RULE_ALT:     re = (n % 2 == 0) ? AMP : -AMP;
			RULE_COS:     re = (n % 4 == 0) ? AMP : ((n % 4 == 2) ? -AMP : 0);
			default:      re = 0;
		endcase
		s.re = re[IN_W-1:0];
		s.im = '0;	// Real stimulus only
		return s;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	initial
	begin
		int   rule;
		int   n;
		logic b0;
		logic b1;
		RST     = 1'b1;
		valid_i = 1'b0;
		data_i  = '0;
		repeat (2) @(posedge CLK);
		RST <= 1'b0;
		for (int f = 0; f <= NUM_FRAMES; f++)
		begin
			rule = (f < NUM_FRAMES) ? frame_rule[f] : RULE_ZERO;	// Last pass flushes
			n    = 0;
			while (n < FFT_N)
			begin
				@(posedge CLK);
				lfsr = lfsr_next(lfsr);
				b0   = lfsr[0];
				lfsr = lfsr_next(lfsr);
				b1   = lfsr[0];
				if (b0 && b1)
					valid_i <= 1'b0;	// Gap about one cycle in four
				else
				begin
					valid_i <= 1'b1;
					data_i  <= make_sample(rule, n);
					n++;
				end
			end
		end
		@(posedge CLK);
		valid_i <= 1'b0;
		wait (frames_done == NUM_FRAMES);
		@(posedge CLK);
		$display("ALL TESTS PASSED");
		$finish;
	end

	// Output side sampled away from the driving edge
	always @(negedge CLK)
	begin
		int   bin;
		int   exp_re;
		int   exp_im;
		int   act_re;
		int   act_im;
		logic exp_first;
		cycle_cnt++;
		assert (cycle_cnt < TIMEOUT_CYCLES) else fail_run("timeout waiting for output");
		if (!RST)
		begin
			assert (!(first_o && !valid_o))
				else fail_run("first_o high while valid_o is low");
			if (!started)
				assert (!valid_o || first_o)
					else fail_run("valid_o high before the first frame emerged");
			if (valid_o && frames_done < NUM_FRAMES)
			begin
				started   = 1'b1;
				exp_first = (sample_idx == 0);	// Bin 0 opens each frame
				assert (first_o == exp_first)
					else fail_run($sformatf(
						"FAILED %s first_o at sample %0d: expected %0b, actual %0b",
						frame_name[frames_done], sample_idx, exp_first, first_o));
				bin    = bit_reverse(sample_idx);	// Output comes in bit-reversed order
				exp_re = bin_re[frames_done][bin];
				exp_im = bin_im[frames_done][bin];
				act_re = data_o.re;
				act_im = data_o.im;
				assert (act_re == exp_re && act_im == exp_im)
					else fail_run($sformatf(
						"FAILED %s bin %0d: expected (%0d, %0d), actual (%0d, %0d)",
						frame_name[frames_done], bin, exp_re, exp_im, act_re, act_im));
				sample_idx++;
				if (sample_idx == FFT_N)
				begin
					sample_idx = 0;
					frames_done++;	// Next first_o due now
				end
			end
		end
	end

endmodule

/* rtl/sdf_fft_top.sv */
module sdf_fft_top import fft_pkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  logic    valid_i,	// One sample per high cycle
	input  cplx12_t data_i,
	output logic    valid_o,
	output logic    first_o,	// Bin 0 of a frame
	output cplx16_t data_o	// Bins in bit-reversed order
)
;
	// Chain lag in valid samples, 8 + 4 + 2 + 1
	localparam cnt_t LAG = cnt_t'(FFT_N - 1);

	logic    v1;
	logic    v2;
	logic    vt;
	logic    v3;
	logic    v4;
	cplx13_t d1;
	cplx14_t d2;
	cplx14_t dt;
	cplx15_t d3;
	cplx16_t d4;
	cnt_t    out_cnt;
	cnt_t    out_pos;
	logic    primed;	// First real frame has reached the output
	logic    at_bin0;

	sdf_bf_stage #(
		.DEPTH       (8),
		.ROT_MINUS_J (1'b1),
		.in_t        (cplx12_t),
		.out_t       (cplx13_t)
	) u_stage1 (
		.CLK     (CLK),
		.RST     (RST),
		.valid_i (valid_i),
		.data_i  (data_i),
		.valid_o (v1),
		.data_o  (d1)
	);

	sdf_bf_stage #(
		.DEPTH       (4),
		.ROT_MINUS_J (1'b0),
		.in_t        (cplx13_t),
		.out_t       (cplx14_t)
	) u_stage2 (
		.CLK     (CLK),
		.RST     (RST),
		.valid_i (v1),
		.data_i  (d1),
		.valid_o (v2),
		.data_o  (d2)
	);

	sdf_twiddle_mul u_twiddle (	// Between the two stage pairs
		.CLK     (CLK),
		.RST     (RST),
		.valid_i (v2),
		.data_i  (d2),
		.valid_o (vt),
		.data_o  (dt)
	);

	sdf_bf_stage #(
		.DEPTH       (2),
		.ROT_MINUS_J (1'b1),
		.in_t        (cplx14_t),
		.out_t       (cplx15_t)
	) u_stage3 (
		.CLK     (CLK),
		.RST     (RST),
		.valid_i (vt),
		.data_i  (dt),
		.valid_o (v3),
		.data_o  (d3)
	);

	sdf_bf_stage #(
		.DEPTH       (1),
		.ROT_MINUS_J (1'b0),
		.in_t        (cplx15_t),
		.out_t       (cplx16_t)
	) u_stage4 (
		.CLK     (CLK),
		.RST     (RST),
		.valid_i (v3),
		.data_i  (d3),
		.valid_o (v4),
		.data_o  (d4)
	);

	assign out_pos = out_cnt - LAG;	// Frame position of the current output
	assign at_bin0 = (out_pos == '0);

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			out_cnt <= '0;
			primed  <= 1'b0;
		end
		else if (v4)
		begin
			out_cnt <= out_cnt + 1'b1;
			if (at_bin0)
				primed <= 1'b1;	// Fill samples are behind us
		end
	end

	assign valid_o = v4 && (primed || at_bin0);	// Hide the buffer fill
	assign first_o = v4 && at_bin0;
	assign data_o  = d4;

endmodule

/* rtl/sdf_twiddle_mul.sv */
module sdf_twiddle_mul import fft_pkg::*, twiddle_pkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  logic    valid_i,
	input  cplx14_t data_i,
	output logic    valid_o,
	output cplx14_t data_o
);

	localparam int DW = $bits(cplx14_t) / 2;	// Component width
	localparam int PW = DW + TW_W + 1;	// Room for the sum of two products
	localparam logic signed [PW-1:0] RND = PW'(2 ** (TW_FRAC - 1));	// Half an LSB
	// Frames reach this point 8 + 4 samples late
	localparam cnt_t LAG = cnt_t'(FFT_N / 2 + FFT_N / 4);

	cnt_t                   cnt;
	cnt_t                   pos_cnt;
	logic [1:0]             grp;
	logic [1:0]             pos;
	logic [1:0]             mult;
	logic [3:0]             expo;
	logic signed [TW_W-1:0] w_re;
	logic signed [TW_W-1:0] w_im;
	logic signed [PW-1:0]   p_re;
	logic signed [PW-1:0]   p_im;
	logic signed [PW-1:0]   r_re;
	logic signed [PW-1:0]   r_im;

	assign pos_cnt = cnt - LAG;	// Position inside the frame
	assign grp     = pos_cnt[3:2];	// Which quarter of stage two's output
	assign pos     = pos_cnt[1:0];	// Index inside the quarter
	assign mult    = {grp[0], grp[1]};	// 0, 2, 1, 3 is the group bit-reversed
	assign expo    = {2'b00, pos} * {2'b00, mult};	// At most 3 * 3

	assign w_re = TW_COS[expo];	// ROM lookup
	assign w_im = TW_SIN[expo];

	always_comb
	begin
		p_re = data_i.re * w_re - data_i.im * w_im;	// Full precision complex product
		p_im = data_i.re * w_im + data_i.im * w_re;
		r_re = (p_re + RND) >>> TW_FRAC;	// Round half up, drop fraction
		r_im = (p_im + RND) >>> TW_FRAC;
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			cnt     <= '0;
			valid_o <= 1'b0;
		end
		else
		begin
			valid_o <= valid_i;
			if (valid_i)
				cnt <= cnt + 1'b1;	// Own frame counter
		end
	end

	always_ff @(posedge CLK)
	begin
		if (valid_i)
		begin
			data_o.re <= r_re[DW-1:0];	// Magnitude of W is one, so no growth
			data_o.im <= r_im[DW-1:0];
		end
	end

	// Mapping from counter to exponent stays inside the first ten ROM entries
	a_expo_range: assert property (@(posedge CLK) disable iff (RST)
		valid_i |-> expo <= 4'd9);

endmodule

/* rtl/sdf_bf_stage.sv */
module sdf_bf_stage import fft_pkg::*;
#(
	parameter int  DEPTH       = 8,	// Feedback buffer length, half the butterfly span
	parameter bit  ROT_MINUS_J = 1'b0,	// Trivial -j on the last quarter
	parameter type in_t        = cplx12_t,
	parameter type out_t       = cplx13_t
)
(
	input  logic CLK,
	input  logic RST,
	input  logic valid_i,
	input  in_t  data_i,
	output logic valid_o,
	output out_t data_o
);

	localparam int IW = $bits(in_t) / 2;	// Input component width
	localparam int OW = $bits(out_t) / 2;	// Output component width, one bit more
	localparam int CW = $clog2(2 * DEPTH);	// Counter over one 2*DEPTH group

	logic [CW-1:0]        cnt;
	logic                 second_half;
	logic                 rot;
	logic signed [IW-1:0] in_re;
	logic signed [IW-1:0] in_im;
	logic signed [OW-1:0] b_re;
	logic signed [OW-1:0] b_im;
	logic signed [OW-1:0] a_re;
	logic signed [OW-1:0] a_im;
	logic signed [OW-1:0] res_re;
	logic signed [OW-1:0] res_im;
	logic signed [OW-1:0] fb_re;
	logic signed [OW-1:0] fb_im;
	logic signed [OW-1:0] out_re;
	logic signed [OW-1:0] out_im;
	out_t                 buf_q;
	out_t                 buf_d;

	assign in_re = data_i[2*IW-1:IW];	// Real in upper half
	assign in_im = data_i[IW-1:0];
	assign b_re  = in_re;	// Sign extend to stage width
	assign b_im  = in_im;
	assign a_re  = buf_q[2*OW-1:OW];	// Sample from DEPTH earlier
	assign a_im  = buf_q[OW-1:0];

	assign second_half = cnt[CW-1];	// Butterfly half of the group
	// Diffs with index DEPTH/2 and up land in the last output quarter
	assign rot = ROT_MINUS_J && !second_half && (cnt >= CW'(DEPTH / 2));

	always_comb
	begin
		if (second_half)
		begin
			res_re = a_re + b_re;	// Upper result goes out
			res_im = a_im + b_im;
			fb_re  = a_re - b_re;	// Lower result waits in the buffer
			fb_im  = a_im - b_im;
		end
		else
		begin
			res_re = a_re;	// Drain last group's differences
			res_im = a_im;
			fb_re  = b_re;	// Park the first half of the input
			fb_im  = b_im;
		end
		out_re = rot ? res_im : res_re;	// (re + j im) * -j = im - j re
		out_im = rot ? -res_re : res_im;
	end

	assign buf_d = out_t'({fb_re, fb_im});

	sdf_delay_line #(
		.DEPTH  (DEPTH),
		.data_t (out_t)
	) u_delay_line (
		.CLK     (CLK),
		.RST     (RST),
		.shift_i (valid_i),	// Frozen during gaps
		.data_i  (buf_d),
		.data_o  (buf_q)
	);

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			cnt     <= '0;
			valid_o <= 1'b0;
		end
		else
		begin
			valid_o <= valid_i;	// One register behind the input
			if (valid_i)
				cnt <= cnt + 1'b1;	// Wraps at 2*DEPTH
		end
	end

	always_ff @(posedge CLK)
	begin
		if (valid_i)
			data_o <= out_t'({out_re, out_im});
	end

	a_valid_known: assert property (@(posedge CLK) disable iff (RST) !$isunknown(valid_o));
	a_valid_follows: assert property (@(posedge CLK) disable iff (RST)
		$rose(valid_o) |-> $past(valid_i));

endmodule

/* rtl/sdf_delay_line.sv */
module sdf_delay_line
#(
	parameter int  DEPTH  = 8,	// Number of entries
	parameter type data_t = logic	// Payload carried per entry
)
(
	input  logic  CLK,
	input  logic  RST,
	input  logic  shift_i,	// Advance one place
	input  data_t data_i,
	output data_t data_o	// Oldest entry
);

	data_t mem [DEPTH];	// mem[0] is the newest

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;	// Buffer starts empty
		end
		else if (shift_i)
		begin
			mem[0] <= data_i;
			for (int i = 1; i < DEPTH; i++)
				mem[i] <= mem[i-1];	// Move toward the tail
		end
	end

	assign data_o = mem[DEPTH-1];

endmodule

/* rtl/twiddle_pkg.sv */
package twiddle_pkg;

	localparam int TW_W    = 16;	// Signed Q2.14 coefficient
	localparam int TW_FRAC = 14;	// Fraction bits, 1.0 is 16384

	// W^e = cos(2*pi*e/16) - j*sin(2*pi*e/16)
	localparam logic signed [TW_W-1:0] TW_COS [16] = '{
		16384,
		15137,
		11585,
		6270,
		0,	// Quarter turn
		-6270,
		-11585,
		-15137,
		-16384,	// Half turn
		-15137,
		-11585,
		-6270,
		0,
		6270,
		11585,
		15137
	};

	// Imaginary part already negated
	localparam logic signed [TW_W-1:0] TW_SIN [16] = '{
		0,     -6270, -11585, -15137,
		-16384, -15137, -11585, -6270,
		0,      6270,  11585,  15137,
		16384,  15137,  11585,  6270
	};

endpackage

/* rtl/fft_pkg.sv */
package fft_pkg;

	localparam int FFT_N  = 16;	// Points per frame
	localparam int LOG2_N = 4;	// Butterfly stages
	localparam int IN_W   = 12;	// Input component width
	localparam int OUT_W  = 16;	// Output width, input plus one bit per butterfly

	typedef logic [LOG2_N-1:0] cnt_t;	// Sample index inside a frame

	// Packed complex samples, real part in the upper half
	typedef struct packed
	{
		logic signed [IN_W-1:0] re;	// Input stage
		logic signed [IN_W-1:0] im;
	} cplx12_t;

	typedef struct packed
	{
		logic signed [IN_W:0] re;	// After stage one
		logic signed [IN_W:0] im;
	} cplx13_t;

	typedef struct packed
	{
		logic signed [IN_W+1:0] re;	// After stage two and the twiddle
		logic signed [IN_W+1:0] im;
	} cplx14_t;

	typedef struct packed
	{
		logic signed [IN_W+2:0] re;	// After stage three
		logic signed [IN_W+2:0] im;
	} cplx15_t;

	typedef struct packed
	{
		logic signed [OUT_W-1:0] re;	// Final output
		logic signed [OUT_W-1:0] im;
	} cplx16_t;

endpackage
